// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) hdl/*.sv dv/*.sv dv/*.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+dv
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_match.sv
hdl/tlb_lookup_port.sv
hdl/tlb_top.sv
dv/tlb_tb.sv

// ==== dv/tlb_tb_model.svh ====
// mirror of the entry table kept in step with the DUT inputs
tlb_pkg::tlb_entry_t model_tab [tlb_num];

function automatic logic page_match(tlb_pkg::tlb_entry_t en, logic [31:0] va);
    if (en.ps == tlb_pkg::ps_4k) return en.vpn2 == va[31:13];
    if (en.ps == tlb_pkg::ps_2m) return en.vpn2[18:9] == va[31:22];
    return 1'b0;
endfunction

function automatic void lowest_hit(input logic [31:0] va, input logic [9:0] asid,
                                   output logic hit, output logic [idx_w-1:0] idx);
    tlb_pkg::tlb_entry_t en;
    hit = 1'b0;
    idx = '0;
    for (int i = tlb_num - 1; i >= 0; i--) begin
        en = model_tab[i];
        if (en.e && page_match(en, va) && (en.g || en.asid == asid)) begin
            hit = 1'b1;
            idx = idx_w'(i);
        end
    end
endfunction

function automatic void ref_search(input logic [18:0] vpn2, input logic [9:0] asid,
                                   output logic hit, output logic [idx_w-1:0] idx);
    lowest_hit({vpn2, 13'h0}, asid, hit, idx);
endfunction

function automatic void ref_translate(input logic [1:0] mode, input logic [31:0] va,
                                      input logic [9:0] asid, input logic [1:0] plv,
                                      input logic [1:0] mt, output logic [31:0] pa,
                                      output logic [tlb_pkg::exc_w-1:0] exc);
    logic                hit;
    logic [idx_w-1:0]    idx;
    tlb_pkg::tlb_entry_t en;
    logic                odd;
    logic [19:0]         pfn;
    logic [1:0]          pplv;
    logic                pd;
    logic                pv;
    pa  = va;
    exc = '0;
    if (mode != tlb_pkg::ad_mapped) return;
    lowest_hit(va, asid, hit, idx);
    en   = model_tab[idx];
    odd  = (en.ps == tlb_pkg::ps_2m) ? va[21] : va[12];
    pfn  = odd ? en.pfn1 : en.pfn0;
    pplv = odd ? en.plv1 : en.plv0;
    pd   = odd ? en.d1 : en.d0;
    pv   = odd ? en.v1 : en.v0;
    pa   = (en.ps == tlb_pkg::ps_2m) ? {pfn[19:9], va[20:0]} : {pfn, va[11:0]};
    if (plv == 2'd3 && va[31]) exc[tlb_pkg::exc_adem] = 1'b1;
    else if (!hit) exc[tlb_pkg::exc_refill] = 1'b1;
    else if (!pv) begin
        if (mt == tlb_pkg::mem_fetch) exc[tlb_pkg::exc_pif] = 1'b1;
        else if (mt == tlb_pkg::mem_load) exc[tlb_pkg::exc_pil] = 1'b1;
        else exc[tlb_pkg::exc_pis] = 1'b1;
    end
    else if (plv > pplv) exc[tlb_pkg::exc_ppi] = 1'b1;
    else if (mt == tlb_pkg::mem_store && !pd) exc[tlb_pkg::exc_pme] = 1'b1;
endfunction

function automatic void ref_invalidate(input logic [2:0] op, input logic [9:0] asid,
                                       input logic [31:0] va);
    tlb_pkg::tlb_entry_t en;
    logic                q;
    for (int i = 0; i < tlb_num; i++) begin
        en = model_tab[i];
        case (op)
            3'd0, 3'd1: q = 1'b1;
            3'd2:       q = en.g;
            3'd3:       q = !en.g;
            3'd4:       q = !en.g && en.asid == asid;
            3'd5:       q = !en.g && en.asid == asid && page_match(en, va);
            3'd6:       q = (en.g || en.asid == asid) && page_match(en, va);
            default:    q = 1'b0;
        endcase
        if (q) model_tab[i].e = 1'b0;
    end
endfunction

// ==== dv/tlb_tb.sv ====
`timescale 1ns/1ps

module tlb_tb;
    localparam int tlb_num = 16;
    localparam int idx_w = $clog2(tlb_num);

    logic clk, rst;
    logic [1:0] ad_mode;
    logic [31:0] s0_vaddr, s1_vaddr, s0_paddr, s1_paddr, clear_vaddr;
    logic [9:0] s0_asid, s1_asid, s_asid, clear_asid;
    logic [1:0] s0_plv, s1_plv, s0_mem_type, s1_mem_type;
    logic s0_en, s1_en, we, fill_mode, check_mode, rs_e, clear_en;
    logic [tlb_pkg::exc_w-1:0] s0_exception, s1_exception;
    logic [idx_w-1:0] w_index, f_index, r_index, s_index;
    tlb_pkg::tlb_entry_t w_entry, r_entry;
    logic [18:0] s_vpn2;
    logic [2:0] clear_mem;

    // registered requests as the DUT should hold them
    logic [1:0] m0_mode, m1_mode, m0_plv, m1_plv, m0_mt, m1_mt;
    logic [31:0] m0_va, m1_va;
    logic [9:0] m0_asid, m1_asid;
    logic [31:0] lfsr = 32'h215f5775;
    int err_count = 0;
    int check_count = 0;
    int test_base = 0;

    `include "tlb_tb_model.svh"

    tlb_top #(.tlb_num(tlb_num)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_paddr(input string name, input logic [31:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_exc(input string name, input logic [tlb_pkg::exc_w-1:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_index(input string name, input logic [idx_w-1:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_entry(input string name, input tlb_pkg::tlb_entry_t got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // follow the table and the request registers edge by edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tlb_num; i++) model_tab[i].e = 1'b0;
            {m0_mode, m0_va, m0_asid, m0_plv, m0_mt} = '0;
            {m1_mode, m1_va, m1_asid, m1_plv, m1_mt} = '0;
        end else begin
            if (clear_en) ref_invalidate(clear_mem, clear_asid, clear_vaddr);
            if (we) model_tab[fill_mode ? f_index : w_index] = w_entry;
            if (s0_en) {m0_mode, m0_va, m0_asid, m0_plv, m0_mt} =
                {ad_mode, s0_vaddr, s0_asid, s0_plv, s0_mem_type};
            if (s1_en) {m1_mode, m1_va, m1_asid, m1_plv, m1_mt} =
                {ad_mode, s1_vaddr, s1_asid, s1_plv, s1_mem_type};
        end
    end

    // port results compared mid-cycle on every cycle
    always @(negedge clk) begin
        logic [31:0] pa;
        logic [tlb_pkg::exc_w-1:0] ex;
        if (!rst) begin
            ref_translate(m0_mode, m0_va, m0_asid, m0_plv, m0_mt, pa, ex);
            check_exc("s0_exception", s0_exception, ex);
            if (ex == '0) check_paddr("s0_paddr", s0_paddr, pa);
            ref_translate(m1_mode, m1_va, m1_asid, m1_plv, m1_mt, pa, ex);
            check_exc("s1_exception", s1_exception, ex);
            if (ex == '0) check_paddr("s1_paddr", s1_paddr, pa);
        end
    end

    function automatic tlb_pkg::tlb_entry_t make_entry();
        tlb_pkg::tlb_entry_t en;
        en = '0;
        en.e = (rand_bits(3) != 0);
        en.vpn2 = 19'(rand_bits(19));
        en.asid = 10'(rand_bits(2));
        en.ps = rand_bits(1) != 0 ? tlb_pkg::ps_2m : tlb_pkg::ps_4k;
        en.g = (rand_bits(2) == 0);
        en.pfn0 = 20'(rand_bits(20));
        en.mat0 = 2'(rand_bits(2));
        en.plv0 = 2'(rand_bits(2));
        en.d0 = rand_bits(1) != 0;
        en.v0 = rand_bits(2) != 0;
        en.pfn1 = 20'(rand_bits(20));
        en.mat1 = 2'(rand_bits(2));
        en.plv1 = 2'(rand_bits(2));
        en.d1 = rand_bits(1) != 0;
        en.v1 = rand_bits(2) != 0;
        return en;
    endfunction

    // mostly addresses that land on a table entry
    function automatic void pick_request(input logic mapped, output logic [31:0] va,
                                         output logic [9:0] asid);
        tlb_pkg::tlb_entry_t en;
        en = model_tab[4'(rand_bits(4))];
        va = rand_bits(32);
        asid = 10'(rand_bits(2));
        if (mapped && rand_bits(3) != 0) begin
            if (en.ps == tlb_pkg::ps_2m) va = {en.vpn2[18:9], 22'(rand_bits(22))};
            else va = {en.vpn2, 13'(rand_bits(13))};
            if (rand_bits(1) != 0) asid = en.asid;
        end
    endfunction

    function automatic logic [1:0] rand_type();
        logic [1:0] mt;
        mt = 2'(rand_bits(2));
        return mt == 2'd3 ? tlb_pkg::mem_store : mt;
    endfunction

    task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t en, input logic fill);
        @(posedge clk);
        we <= 1'b1;
        fill_mode <= fill;
        w_entry <= en;
        w_index <= fill ? 4'(rand_bits(4)) : 4'(idx);
        f_index <= fill ? 4'(idx) : 4'(rand_bits(4));
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic fill_table();
        for (int i = 0; i < tlb_num; i++) write_entry(i, make_entry(), i % 2 == 1);
    endtask

    task automatic random_lookups(input int n, input logic mapped);
        logic [31:0] va0, va1;
        logic [9:0] as0, as1;
        for (int k = 0; k < n; k++) begin
            pick_request(mapped, va0, as0);
            pick_request(mapped, va1, as1);
            @(posedge clk);
            ad_mode <= mapped ? tlb_pkg::ad_mapped : tlb_pkg::ad_direct;
            {s0_en, s0_vaddr, s0_asid, s0_plv, s0_mem_type} <=
                {1'b1, va0, as0, 2'(rand_bits(2)), rand_type()};
            {s1_en, s1_vaddr, s1_asid, s1_plv, s1_mem_type} <=
                {1'b1, va1, as1, 2'(rand_bits(2)), rand_type()};
        end
        @(posedge clk);
        s0_en <= 1'b0;
        s1_en <= 1'b0;
    endtask

    // both ports get the same request and must raise exactly exp
    task automatic targeted(input logic [31:0] va, input logic [1:0] plv, mt,
                            input logic [tlb_pkg::exc_w-1:0] exp);
        @(posedge clk);
        ad_mode <= tlb_pkg::ad_mapped;
        {s0_en, s0_vaddr, s0_asid, s0_plv, s0_mem_type} <= {1'b1, va, 10'd5, plv, mt};
        {s1_en, s1_vaddr, s1_asid, s1_plv, s1_mem_type} <= {1'b1, va, 10'd5, plv, mt};
        @(posedge clk);
        s0_en <= 1'b0;
        s1_en <= 1'b0;
        @(negedge clk);
        check_exc("s0_exception", s0_exception, exp);
        check_exc("s1_exception", s1_exception, exp);
    endtask

    task automatic read_all();
        for (int i = 0; i < tlb_num; i++) begin
            @(posedge clk);
            r_index <= 4'(i);
            check_mode <= 1'b0;
            @(negedge clk);
            check_entry("r_entry", r_entry, model_tab[i]);
            check_bit("rs_e", rs_e, model_tab[i].e);
        end
    endtask

    task automatic search_all();
        logic [18:0] key;
        logic hit;
        logic [idx_w-1:0] idx;
        for (int i = 0; i < tlb_num; i++) begin
            key = rand_bits(2) != 0 ? model_tab[i].vpn2 : 19'(rand_bits(19));
            @(posedge clk);
            check_mode <= 1'b1;
            s_vpn2 <= key;
            s_asid <= model_tab[i].asid;
            @(negedge clk);
            ref_search(key, model_tab[i].asid, hit, idx);
            check_bit("rs_e", rs_e, hit);
            if (hit) check_index("s_index", s_index, idx);
        end
    endtask

    task automatic invalidate(input logic [2:0] op, input logic with_write);
        int j;
        tlb_pkg::tlb_entry_t en;
        j = int'(rand_bits(4));
        en = make_entry();
        en.e = 1'b1;
        @(posedge clk);
        clear_en <= 1'b1;
        clear_mem <= op;
        clear_asid <= model_tab[j].asid;
        clear_vaddr <= {model_tab[j].vpn2, 13'(rand_bits(13))};
        if (with_write) begin
            we <= 1'b1;
            fill_mode <= 1'b0;
            w_index <= 4'(j);
            w_entry <= en;
        end
        @(posedge clk);
        clear_en <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_base) $display("[%s] ok", name);
        else $display("[%s] %0d errors", name, err_count - test_base);
        test_base = err_count;
    endtask

    initial begin
        repeat (100000) @(posedge clk);
        $display("timeout: the test sequence did not finish");
        $display("test failed");
        $finish;
    end

    initial begin
        rst <= 1'b1;
        ad_mode <= tlb_pkg::ad_direct;
        {s0_vaddr, s0_asid, s0_plv, s0_mem_type, s0_en} <= '0;
        {s1_vaddr, s1_asid, s1_plv, s1_mem_type, s1_en} <= '0;
        {we, fill_mode, w_index, f_index, w_entry, r_index} <= '0;
        {check_mode, s_vpn2, s_asid} <= '0;
        {clear_en, clear_mem, clear_asid, clear_vaddr} <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        random_lookups(20, 1'b0);
        end_test("direct mode after reset");
        fill_table();
        random_lookups(200, 1'b1);
        end_test("random mapped lookups");
        invalidate(tlb_pkg::inv_all0, 1'b0);
        write_entry(3, {1'b1, 19'h10, 10'd5, tlb_pkg::ps_4k, 1'b0,
                        20'h12345, 2'd1, 2'd0, 1'b0, 1'b1,
                        20'h54321, 2'd1, 2'd0, 1'b1, 1'b0}, 1'b0);
        targeted(32'h0004_0abc, 2'd0, tlb_pkg::mem_load, 7'(1 << tlb_pkg::exc_refill));
        targeted(32'h0002_1abc, 2'd0, tlb_pkg::mem_fetch, 7'(1 << tlb_pkg::exc_pif));
        targeted(32'h0002_1abc, 2'd0, tlb_pkg::mem_load, 7'(1 << tlb_pkg::exc_pil));
        targeted(32'h0002_1abc, 2'd0, tlb_pkg::mem_store, 7'(1 << tlb_pkg::exc_pis));
        targeted(32'h0002_0abc, 2'd3, tlb_pkg::mem_load, 7'(1 << tlb_pkg::exc_ppi));
        targeted(32'h0002_0abc, 2'd0, tlb_pkg::mem_store, 7'(1 << tlb_pkg::exc_pme));
        targeted(32'h8002_0abc, 2'd3, tlb_pkg::mem_load, 7'(1 << tlb_pkg::exc_adem));
        targeted(32'h0002_0abc, 2'd0, tlb_pkg::mem_load, '0);
        check_paddr("s0_paddr", s0_paddr, 32'h1234_5abc);
        end_test("targeted exceptions");
        fill_table();
        read_all();
        search_all();
        end_test("read and search ports");
        for (int op = 0; op < 7; op++) begin
            fill_table();
            invalidate(3'(op), op % 2 == 0);
            read_all();
            random_lookups(16, 1'b1);
        end
        end_test("invalidate ops");
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

// ==== hdl/tlb_entry_array.sv ====
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               we,
    input  logic                               fill_mode,
    input  logic [idx_w-1:0]                   w_index,
    input  logic [idx_w-1:0]                   f_index,
    input  tlb_pkg::tlb_entry_t                w_entry,

    input  logic [idx_w-1:0]                   r_index,
    output tlb_pkg::tlb_entry_t                r_entry,

    input  logic                               clear_en,
    input  logic [2:0]                         clear_mem,
    input  logic [tlb_pkg::asid_w-1:0]         clear_asid,
    input  logic [31:0]                        clear_vaddr,

    output tlb_pkg::tlb_entry_t [tlb_num-1:0]  entries
);

    // valid bits kept apart from the entry bodies
    logic [tlb_num-1:0]  e_bits;
    tlb_pkg::tlb_entry_t body [tlb_num];

    logic [idx_w-1:0]    wi;
    logic [tlb_num-1:0]  clr_vec;

    assign wi = fill_mode ? f_index : w_index;

    // qualify each entry for the requested invtlb op
    always_comb begin
        logic asid_eq;
        logic va_eq;
        logic g;
        for (int i = 0; i < tlb_num; i++) begin
            g       = body[i].g;
            asid_eq = (body[i].asid == clear_asid);
            va_eq   = 1'b0;
            if (body[i].ps == tlb_pkg::ps_4k) begin
                va_eq = (body[i].vpn2 == clear_vaddr[31:13]);
            end else if (body[i].ps == tlb_pkg::ps_2m) begin
                va_eq = (body[i].vpn2[18:9] == clear_vaddr[31:22]);
            end
            case (clear_mem)
                tlb_pkg::inv_all0,
                tlb_pkg::inv_all1:        clr_vec[i] = 1'b1;
                tlb_pkg::inv_glb:         clr_vec[i] = g;
                tlb_pkg::inv_nglb:        clr_vec[i] = !g;
                tlb_pkg::inv_asid:        clr_vec[i] = !g && asid_eq;
                tlb_pkg::inv_asid_va:     clr_vec[i] = !g && asid_eq && va_eq;
                tlb_pkg::inv_glb_asid_va: clr_vec[i] = (g || asid_eq) && va_eq;
                default:                  clr_vec[i] = 1'b0;
            endcase
        end
    end

    // write comes last so it wins over a clear at its index
    always_ff @(posedge clk) begin
        if (rst) begin
            e_bits <= '0;
        end else begin
            if (clear_en) begin
                e_bits <= e_bits & ~clr_vec;
            end
            if (we) begin
                e_bits[wi] <= w_entry.e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            body[wi] <= w_entry;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            entries[i]   = body[i];
            entries[i].e = e_bits[i];
        end
    end

    assign r_entry = entries[r_index];

endmodule

// ==== hdl/tlb_lookup_port.sv ====
`timescale 1ns/1ps

module tlb_lookup_port #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              en,
    input  logic [1:0]                        ad_mode,
    input  logic [31:0]                       vaddr,
    input  logic [tlb_pkg::asid_w-1:0]        asid,
    input  logic [1:0]                        plv,
    input  logic [1:0]                        mem_type,
    input  tlb_pkg::tlb_entry_t [tlb_num-1:0] entries,
    output logic [31:0]                       paddr,
    output logic [tlb_pkg::exc_w-1:0]         exception
);

    logic [1:0]                 mode_q;
    logic [31:0]                vaddr_q;
    logic [tlb_pkg::asid_w-1:0] asid_q;
    logic [1:0]                 plv_q;
    logic [1:0]                 type_q;

    logic                       hit;
    logic [idx_w-1:0]           hit_index;
    tlb_pkg::tlb_entry_t        sel;
    logic                       is_2m;
    logic                       odd;
    logic [tlb_pkg::pfn_w-1:0]  page_pfn;
    logic [1:0]                 page_plv;
    logic                       page_d;
    logic                       page_v;

    // request register holds its value while idle
    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q  <= tlb_pkg::ad_direct;
            vaddr_q <= '0;
            asid_q  <= '0;
            plv_q   <= '0;
            type_q  <= '0;
        end else if (en) begin
            mode_q  <= ad_mode;
            vaddr_q <= vaddr;
            asid_q  <= asid;
            plv_q   <= plv;
            type_q  <= mem_type;
        end
    end

    tlb_match #(
        .tlb_num   (tlb_num)
    ) u_match (
        .entries   (entries),
        .vaddr_hi  (vaddr_q[31:12]),
        .asid      (asid_q),
        .hit_vec   (),
        .hit       (hit),
        .hit_index (hit_index)
    );

    assign sel   = entries[hit_index];
    assign is_2m = (sel.ps == tlb_pkg::ps_2m);
    assign odd   = is_2m ? vaddr_q[21] : vaddr_q[12];

    // even or odd half of the pair
    assign page_pfn = odd ? sel.pfn1 : sel.pfn0;
    assign page_plv = odd ? sel.plv1 : sel.plv0;
    assign page_d   = odd ? sel.d1   : sel.d0;
    assign page_v   = odd ? sel.v1   : sel.v0;

    always_comb begin
        paddr     = vaddr_q;
        exception = '0;
        if (mode_q == tlb_pkg::ad_mapped) begin
            paddr = is_2m ? {page_pfn[19:9], vaddr_q[20:0]}
                          : {page_pfn, vaddr_q[11:0]};
            if (plv_q == 2'd3 && vaddr_q[31]) begin
                exception[tlb_pkg::exc_adem] = 1'b1;
            end else if (!hit) begin
                exception[tlb_pkg::exc_refill] = 1'b1;
            end else if (!page_v) begin
                case (type_q)
                    tlb_pkg::mem_fetch: exception[tlb_pkg::exc_pif] = 1'b1;
                    tlb_pkg::mem_load:  exception[tlb_pkg::exc_pil] = 1'b1;
                    tlb_pkg::mem_store: exception[tlb_pkg::exc_pis] = 1'b1;
                    default: ;
                endcase
            end else if (plv_q > page_plv) begin
                exception[tlb_pkg::exc_ppi] = 1'b1;
            end else if (type_q == tlb_pkg::mem_store && !page_d) begin
                exception[tlb_pkg::exc_pme] = 1'b1;
            end
        end
    end

endmodule

// ==== hdl/tlb_match.sv ====
`timescale 1ns/1ps

module tlb_match #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  tlb_pkg::tlb_entry_t [tlb_num-1:0] entries,
    input  logic [19:0]                       vaddr_hi,
    input  logic [tlb_pkg::asid_w-1:0]        asid,
    output logic [tlb_num-1:0]                hit_vec,
    output logic                              hit,
    output logic [idx_w-1:0]                  hit_index
);

    // vaddr_hi is vaddr[31:12]
    always_comb begin
        logic vpn_eq;
        for (int i = 0; i < tlb_num; i++) begin
            vpn_eq = 1'b0;
            if (entries[i].ps == tlb_pkg::ps_4k) begin
                vpn_eq = (entries[i].vpn2 == vaddr_hi[19:1]);
            end else if (entries[i].ps == tlb_pkg::ps_2m) begin
                vpn_eq = (entries[i].vpn2[18:9] == vaddr_hi[19:10]);
            end
            hit_vec[i] = entries[i].e && vpn_eq
                         && (entries[i].g || entries[i].asid == asid);
        end
    end

    assign hit = |hit_vec;

    // scan downward so the lowest hit is kept
    always_comb begin
        hit_index = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_index = idx_w'(i);
            end
        end
    end

endmodule

// ==== hdl/tlb_pkg.sv ====
package tlb_pkg;

    localparam int vpn2_w = 19;
    localparam int asid_w = 10;
    localparam int pfn_w  = 20;
    localparam int exc_w  = 7;

    // legal page size codes in the ps field
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    localparam logic [1:0] mem_fetch = 2'd0;
    localparam logic [1:0] mem_load  = 2'd1;
    localparam logic [1:0] mem_store = 2'd2;

    localparam logic [1:0] ad_direct = 2'd0;
    localparam logic [1:0] ad_mapped = 2'd1;

    // bit positions in the exception vector
    localparam int exc_refill = 0;
    localparam int exc_pif    = 1;
    localparam int exc_pil    = 2;
    localparam int exc_pis    = 3;
    localparam int exc_ppi    = 4;
    localparam int exc_pme    = 5;
    localparam int exc_adem   = 6;

    // invtlb op codes
    localparam logic [2:0] inv_all0        = 3'd0;
    localparam logic [2:0] inv_all1        = 3'd1;
    localparam logic [2:0] inv_glb         = 3'd2;
    localparam logic [2:0] inv_nglb        = 3'd3;
    localparam logic [2:0] inv_asid        = 3'd4;
    localparam logic [2:0] inv_asid_va     = 3'd5;
    localparam logic [2:0] inv_glb_asid_va = 3'd6;

    typedef struct packed {
        logic              e;
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic [5:0]        ps;
        logic              g;
        logic [pfn_w-1:0]  pfn0;
        logic [1:0]        mat0;
        logic [1:0]        plv0;
        logic              d0;
        logic              v0;
        logic [pfn_w-1:0]  pfn1;
        logic [1:0]        mat1;
        logic [1:0]        plv1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

endpackage

// ==== hdl/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  ad_mode,

    // fetch port
    input  logic [31:0]                 s0_vaddr,
    input  logic [tlb_pkg::asid_w-1:0]  s0_asid,
    input  logic [1:0]                  s0_plv,
    input  logic [1:0]                  s0_mem_type,
    input  logic                        s0_en,
    output logic [31:0]                 s0_paddr,
    output logic [tlb_pkg::exc_w-1:0]   s0_exception,

    // data port
    input  logic [31:0]                 s1_vaddr,
    input  logic [tlb_pkg::asid_w-1:0]  s1_asid,
    input  logic [1:0]                  s1_plv,
    input  logic [1:0]                  s1_mem_type,
    input  logic                        s1_en,
    output logic [31:0]                 s1_paddr,
    output logic [tlb_pkg::exc_w-1:0]   s1_exception,

    input  logic                        we,
    input  logic                        fill_mode,
    input  logic [idx_w-1:0]            w_index,
    input  logic [idx_w-1:0]            f_index,
    input  tlb_pkg::tlb_entry_t         w_entry,

    input  logic [idx_w-1:0]            r_index,
    output tlb_pkg::tlb_entry_t         r_entry,

    input  logic                        check_mode,
    input  logic [tlb_pkg::vpn2_w-1:0]  s_vpn2,
    input  logic [tlb_pkg::asid_w-1:0]  s_asid,
    output logic [idx_w-1:0]            s_index,
    output logic                        rs_e,

    input  logic                        clear_en,
    input  logic [2:0]                  clear_mem,
    input  logic [tlb_pkg::asid_w-1:0]  clear_asid,
    input  logic [31:0]                 clear_vaddr
);

    tlb_pkg::tlb_entry_t [tlb_num-1:0] entries;
    logic                              s_e;

    tlb_entry_array #(.tlb_num(tlb_num)) u_array (
        .clk         (clk),
        .rst         (rst),
        .we          (we),
        .fill_mode   (fill_mode),
        .w_index     (w_index),
        .f_index     (f_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry),
        .clear_en    (clear_en),
        .clear_mem   (clear_mem),
        .clear_asid  (clear_asid),
        .clear_vaddr (clear_vaddr),
        .entries     (entries)
    );

    tlb_lookup_port #(.tlb_num(tlb_num)) u_port0 (
        .clk       (clk),
        .rst       (rst),
        .en        (s0_en),
        .ad_mode   (ad_mode),
        .vaddr     (s0_vaddr),
        .asid      (s0_asid),
        .plv       (s0_plv),
        .mem_type  (s0_mem_type),
        .entries   (entries),
        .paddr     (s0_paddr),
        .exception (s0_exception)
    );

    tlb_lookup_port #(.tlb_num(tlb_num)) u_port1 (
        .clk       (clk),
        .rst       (rst),
        .en        (s1_en),
        .ad_mode   (ad_mode),
        .vaddr     (s1_vaddr),
        .asid      (s1_asid),
        .plv       (s1_plv),
        .mem_type  (s1_mem_type),
        .entries   (entries),
        .paddr     (s1_paddr),
        .exception (s1_exception)
    );

    // search key sits at vaddr[31:13] and bit 12 is a don't care
    tlb_match #(.tlb_num(tlb_num)) u_search (
        .entries   (entries),
        .vaddr_hi  ({s_vpn2, 1'b0}),
        .asid      (s_asid),
        .hit_vec   (),
        .hit       (s_e),
        .hit_index (s_index)
    );

    assign rs_e = check_mode ? s_e : r_entry.e;

endmodule
